/* logic/decoder_pkg.sv */
`default_nettype none

package decoder_pkg;

    // stage code, driven by the sequencer and decoded in every unit and link
    localparam int STAGE_WIDTH = 3;

    localparam logic [STAGE_WIDTH-1:0] STAGE_IDLE  = STAGE_WIDTH'(0);
    localparam logic [STAGE_WIDTH-1:0] STAGE_LOAD  = STAGE_WIDTH'(1);
    localparam logic [STAGE_WIDTH-1:0] STAGE_GROW  = STAGE_WIDTH'(2);
    localparam logic [STAGE_WIDTH-1:0] STAGE_MERGE = STAGE_WIDTH'(3);

    // growth counters in links and boundaries, costs up to 15
    localparam int GROWTH_WIDTH = 4;

endpackage

`default_nettype wire

/* logic/pu_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface pu_if #(
    parameter int ADDRESS_WIDTH = 5
);

    // own state of the unit
    logic [ADDRESS_WIDTH-1:0] root;
    logic                     active;

    // entries: up-i, down-i, up-j, down-j, up-k, down-k
    logic [5:0][ADDRESS_WIDTH-1:0] neighbor_root;
    logic [5:0]                    neighbor_active;
    logic [5:0]                    neighbor_grown;

    modport unit (
        output root,
        output active,
        input  neighbor_root,
        input  neighbor_active,
        input  neighbor_grown
    );

    // lattice wiring side
    modport fabric (
        input  root,
        input  active,
        output neighbor_root,
        output neighbor_active,
        output neighbor_grown
    );

endinterface

`default_nettype wire

/* logic/stage_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module stage_sequencer #(
    parameter int PU_COUNT    = 27,
    parameter int GROW_ROUNDS = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start_i,
    input  logic [PU_COUNT-1:0]                 root_changed_i,
    output logic [decoder_pkg::STAGE_WIDTH-1:0] stage_o,
    output logic                                busy_o,
    output logic                                done_o
);

    import decoder_pkg::*;

    localparam int ROUND_WIDTH = $clog2(GROW_ROUNDS) + 1;
    localparam logic [ROUND_WIDTH-1:0] LAST_ROUND = ROUND_WIDTH'(GROW_ROUNDS - 1);

    // merge never ends before its second cycle
    localparam int MIN_MERGE_CYCLES = 2;
    localparam int MERGE_WIDTH = $clog2(MIN_MERGE_CYCLES);
    localparam logic [MERGE_WIDTH-1:0] MERGE_SETTLED = MERGE_WIDTH'(MIN_MERGE_CYCLES - 1);

    logic [STAGE_WIDTH-1:0] stage_q;
    logic [ROUND_WIDTH-1:0] round_count;
    logic [MERGE_WIDTH-1:0] merge_count;
    logic                   changed_q;
    logic                   done_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q     <= STAGE_IDLE;
            round_count <= '0;
            merge_count <= '0;
            changed_q   <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q    <= 1'b0;
            // any unit that moved its root last cycle
            changed_q <= |root_changed_i;
            case (stage_q)
                STAGE_IDLE: begin
                    if (start_i) begin
                        stage_q <= STAGE_LOAD;
                    end
                end
                STAGE_LOAD: begin
                    stage_q     <= STAGE_GROW;
                    round_count <= '0;
                end
                STAGE_GROW: begin
                    stage_q     <= STAGE_MERGE;
                    merge_count <= '0;
                end
                STAGE_MERGE: begin
                    if (merge_count < MERGE_SETTLED) begin
                        merge_count <= merge_count + 1'b1;
                    end else if (!changed_q) begin
                        if (round_count == LAST_ROUND) begin
                            stage_q <= STAGE_IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            stage_q     <= STAGE_GROW;
                            round_count <= round_count + 1'b1;
                        end
                    end
                end
                default: begin
                    stage_q <= STAGE_IDLE;
                end
            endcase
        end
    end

    assign stage_o = stage_q;
    assign busy_o  = (stage_q != STAGE_IDLE);
    assign done_o  = done_q;

endmodule

`default_nettype wire

/* logic/processing_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module processing_unit #(
    parameter int ADDRESS_WIDTH = 5,
    parameter int MY_ADDRESS    = 0,
    parameter int ON_BOUNDARY   = 0,
    parameter int BOUNDARY_COST = 6
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [decoder_pkg::STAGE_WIDTH-1:0] stage_i,
    input  logic                                syndrome_i,
    pu_if.unit                                  nbr,
    output logic                                root_changed_o,
    output logic                                touching_boundary_o
);

    import decoder_pkg::*;

    localparam logic [ADDRESS_WIDTH-1:0] OWN_ROOT = ADDRESS_WIDTH'(MY_ADDRESS);

    logic [ADDRESS_WIDTH-1:0] root_q;
    logic [ADDRESS_WIDTH-1:0] merged_root;
    logic                     active_q;
    logic                     merged_active;

    // smallest root and combined activity over fully grown links
    always_comb begin
        merged_root   = root_q;
        merged_active = active_q;
        for (int d = 0; d < 6; d++) begin
            if (nbr.neighbor_grown[d]) begin
                if (nbr.neighbor_root[d] < merged_root) begin
                    merged_root = nbr.neighbor_root[d];
                end
                merged_active = merged_active | nbr.neighbor_active[d];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            root_q   <= OWN_ROOT;
            active_q <= 1'b0;
        end else if (stage_i == STAGE_LOAD) begin
            root_q   <= OWN_ROOT;
            active_q <= syndrome_i;
        end else if (stage_i == STAGE_MERGE) begin
            root_q   <= merged_root;
            active_q <= merged_active;
        end
    end

    // root moves in this merge cycle
    assign root_changed_o = (stage_i == STAGE_MERGE) && (merged_root != root_q);

    assign nbr.root   = root_q;
    assign nbr.active = active_q;

    if (ON_BOUNDARY != 0) begin : g_boundary
        localparam logic [GROWTH_WIDTH-1:0] BOUNDARY_LIMIT = GROWTH_WIDTH'(BOUNDARY_COST);

        logic [GROWTH_WIDTH-1:0] boundary_growth;

        always_ff @(posedge clk) begin
            if (reset) begin
                boundary_growth <= '0;
            end else if (stage_i == STAGE_LOAD) begin
                boundary_growth <= '0;
            end else if (stage_i == STAGE_GROW && active_q &&
                         boundary_growth != BOUNDARY_LIMIT) begin
                boundary_growth <= boundary_growth + 1'b1;
            end
        end

        assign touching_boundary_o = (boundary_growth == BOUNDARY_LIMIT);
    end else begin : g_interior
        // no boundary edge at this site
        assign touching_boundary_o = 1'b0;
    end

endmodule

`default_nettype wire

/* logic/neighbor_link.sv */
`timescale 1ns/10ps
`default_nettype none

module neighbor_link #(
    parameter int LENGTH = 2
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [decoder_pkg::STAGE_WIDTH-1:0] stage_i,
    input  logic                                a_active_i,
    input  logic                                b_active_i,
    output logic                                fully_grown_o
);

    import decoder_pkg::*;

    localparam logic [GROWTH_WIDTH-1:0] FULL_LENGTH = GROWTH_WIDTH'(LENGTH);

    logic [GROWTH_WIDTH-1:0] growth;
    logic [GROWTH_WIDTH:0]   grown_sum;
    logic [GROWTH_WIDTH-1:0] growth_next;

    // one step per active end, one spare bit before saturation
    always_comb begin
        grown_sum = {1'b0, growth}
                  + {{GROWTH_WIDTH{1'b0}}, a_active_i}
                  + {{GROWTH_WIDTH{1'b0}}, b_active_i};
        if (grown_sum >= {1'b0, FULL_LENGTH}) begin
            growth_next = FULL_LENGTH;
        end else begin
            growth_next = grown_sum[GROWTH_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= '0;
        end else if (stage_i == STAGE_LOAD) begin
            growth <= '0;
        end else if (stage_i == STAGE_GROW) begin
            growth <= growth_next;
        end
    end

    assign fully_grown_o = (growth == FULL_LENGTH);

endmodule

`default_nettype wire

/* logic/surface_decoder_top.sv */
`timescale 1ns/10ps
`default_nettype none

module surface_decoder_top #(
    parameter int CODE_DISTANCE_X = 3,
    parameter int CODE_DISTANCE_Z = 3,
    parameter int WEIGHT_X        = 3,
    parameter int WEIGHT_Z        = 1,
    parameter int WEIGHT_UD       = 1,
    parameter int GROW_ROUNDS     = 4,
    localparam int MEASUREMENT_ROUNDS =
        (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X : CODE_DISTANCE_Z,
    localparam int PU_COUNT      = CODE_DISTANCE_X * CODE_DISTANCE_Z * MEASUREMENT_ROUNDS,
    localparam int ADDRESS_WIDTH = $clog2(PU_COUNT)
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start_i,
    input  logic [PU_COUNT-1:0]               syndrome_i,
    output logic [PU_COUNT*ADDRESS_WIDTH-1:0] roots_o,
    output logic [PU_COUNT-1:0]               touching_boundary_o,
    output logic                              busy_o,
    output logic                              done_o
);

    import decoder_pkg::*;

    localparam int LAYER_SIZE    = CODE_DISTANCE_X * CODE_DISTANCE_Z;
    localparam int BOUNDARY_COST = 2 * WEIGHT_X;

    logic [STAGE_WIDTH-1:0]                 stage;
    logic [PU_COUNT-1:0]                    root_changed;
    logic [PU_COUNT-1:0][ADDRESS_WIDTH-1:0] unit_root;
    logic [PU_COUNT-1:0]                    unit_active;
    // link state, indexed by the lower end of each edge
    logic [PU_COUNT-1:0]                    grown_i;
    logic [PU_COUNT-1:0]                    grown_j;
    logic [PU_COUNT-1:0]                    grown_k;

    stage_sequencer #(
        .PU_COUNT   (PU_COUNT),
        .GROW_ROUNDS(GROW_ROUNDS)
    ) u_stage_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start_i       (start_i),
        .root_changed_i(root_changed),
        .stage_o       (stage),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    assign roots_o = unit_root;

    for (genvar k = 0; k < MEASUREMENT_ROUNDS; k++) begin : g_k
        for (genvar i = 0; i < CODE_DISTANCE_X; i++) begin : g_i
            for (genvar j = 0; j < CODE_DISTANCE_Z; j++) begin : g_j
                localparam int ADDR = k * LAYER_SIZE + i * CODE_DISTANCE_Z + j;

                pu_if #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) u_pu_if ();

                processing_unit #(
                    .ADDRESS_WIDTH(ADDRESS_WIDTH),
                    .MY_ADDRESS   (ADDR),
                    .ON_BOUNDARY  ((i == 0 || i == CODE_DISTANCE_X - 1) ? 1 : 0),
                    .BOUNDARY_COST(BOUNDARY_COST)
                ) u_processing_unit (
                    .clk                (clk),
                    .reset              (reset),
                    .stage_i            (stage),
                    .syndrome_i         (syndrome_i[ADDR]),
                    .nbr                (u_pu_if.unit),
                    .root_changed_o     (root_changed[ADDR]),
                    .touching_boundary_o(touching_boundary_o[ADDR])
                );

                assign unit_root[ADDR]   = u_pu_if.root;
                assign unit_active[ADDR] = u_pu_if.active;

                if (i < CODE_DISTANCE_X - 1) begin : g_up_i
                    neighbor_link #(.LENGTH(2 * WEIGHT_X)) u_link_i (
                        .clk          (clk),
                        .reset        (reset),
                        .stage_i      (stage),
                        .a_active_i   (unit_active[ADDR]),
                        .b_active_i   (unit_active[ADDR + CODE_DISTANCE_Z]),
                        .fully_grown_o(grown_i[ADDR])
                    );
                    assign u_pu_if.neighbor_root[0]   = unit_root[ADDR + CODE_DISTANCE_Z];
                    assign u_pu_if.neighbor_active[0] = unit_active[ADDR + CODE_DISTANCE_Z];
                    assign u_pu_if.neighbor_grown[0]  = grown_i[ADDR];
                end else begin : g_edge_up_i
                    assign grown_i[ADDR]              = 1'b0;
                    assign u_pu_if.neighbor_root[0]   = '0;
                    assign u_pu_if.neighbor_active[0] = 1'b0;
                    assign u_pu_if.neighbor_grown[0]  = 1'b0;
                end

                if (i > 0) begin : g_down_i
                    assign u_pu_if.neighbor_root[1]   = unit_root[ADDR - CODE_DISTANCE_Z];
                    assign u_pu_if.neighbor_active[1] = unit_active[ADDR - CODE_DISTANCE_Z];
                    assign u_pu_if.neighbor_grown[1]  = grown_i[ADDR - CODE_DISTANCE_Z];
                end else begin : g_edge_down_i
                    assign u_pu_if.neighbor_root[1]   = '0;
                    assign u_pu_if.neighbor_active[1] = 1'b0;
                    assign u_pu_if.neighbor_grown[1]  = 1'b0;
                end

                if (j < CODE_DISTANCE_Z - 1) begin : g_up_j
                    neighbor_link #(.LENGTH(2 * WEIGHT_Z)) u_link_j (
                        .clk          (clk),
                        .reset        (reset),
                        .stage_i      (stage),
                        .a_active_i   (unit_active[ADDR]),
                        .b_active_i   (unit_active[ADDR + 1]),
                        .fully_grown_o(grown_j[ADDR])
                    );
                    assign u_pu_if.neighbor_root[2]   = unit_root[ADDR + 1];
                    assign u_pu_if.neighbor_active[2] = unit_active[ADDR + 1];
                    assign u_pu_if.neighbor_grown[2]  = grown_j[ADDR];
                end else begin : g_edge_up_j
                    assign grown_j[ADDR]              = 1'b0;
                    assign u_pu_if.neighbor_root[2]   = '0;
                    assign u_pu_if.neighbor_active[2] = 1'b0;
                    assign u_pu_if.neighbor_grown[2]  = 1'b0;
                end

                if (j > 0) begin : g_down_j
                    assign u_pu_if.neighbor_root[3]   = unit_root[ADDR - 1];
                    assign u_pu_if.neighbor_active[3] = unit_active[ADDR - 1];
                    assign u_pu_if.neighbor_grown[3]  = grown_j[ADDR - 1];
                end else begin : g_edge_down_j
                    assign u_pu_if.neighbor_root[3]   = '0;
                    assign u_pu_if.neighbor_active[3] = 1'b0;
                    assign u_pu_if.neighbor_grown[3]  = 1'b0;
                end

                // measurement rounds, stacked in k
                if (k < MEASUREMENT_ROUNDS - 1) begin : g_up_k
                    neighbor_link #(.LENGTH(2 * WEIGHT_UD)) u_link_k (
                        .clk          (clk),
                        .reset        (reset),
                        .stage_i      (stage),
                        .a_active_i   (unit_active[ADDR]),
                        .b_active_i   (unit_active[ADDR + LAYER_SIZE]),
                        .fully_grown_o(grown_k[ADDR])
                    );
                    assign u_pu_if.neighbor_root[4]   = unit_root[ADDR + LAYER_SIZE];
                    assign u_pu_if.neighbor_active[4] = unit_active[ADDR + LAYER_SIZE];
                    assign u_pu_if.neighbor_grown[4]  = grown_k[ADDR];
                end else begin : g_edge_up_k
                    assign grown_k[ADDR]              = 1'b0;
                    assign u_pu_if.neighbor_root[4]   = '0;
                    assign u_pu_if.neighbor_active[4] = 1'b0;
                    assign u_pu_if.neighbor_grown[4]  = 1'b0;
                end

                if (k > 0) begin : g_down_k
                    assign u_pu_if.neighbor_root[5]   = unit_root[ADDR - LAYER_SIZE];
                    assign u_pu_if.neighbor_active[5] = unit_active[ADDR - LAYER_SIZE];
                    assign u_pu_if.neighbor_grown[5]  = grown_k[ADDR - LAYER_SIZE];
                end else begin : g_edge_down_k
                    assign u_pu_if.neighbor_root[5]   = '0;
                    assign u_pu_if.neighbor_active[5] = 1'b0;
                    assign u_pu_if.neighbor_grown[5]  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/decoder_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder_tb;

    localparam int CODE_DISTANCE_X    = 3;
    localparam int CODE_DISTANCE_Z    = 3;
    localparam int MEASUREMENT_ROUNDS =
        (CODE_DISTANCE_X > CODE_DISTANCE_Z) ? CODE_DISTANCE_X : CODE_DISTANCE_Z;
    localparam int PU_COUNT      = CODE_DISTANCE_X * CODE_DISTANCE_Z * MEASUREMENT_ROUNDS;
    localparam int ADDRESS_WIDTH = $clog2(PU_COUNT);

    // syndrome, one root per unit, boundary vector
    localparam int WORDS_PER_TEST    = PU_COUNT + 2;
    localparam int MAX_TESTS         = 16;
    localparam int STIM_WORDS        = 1 + MAX_TESTS * WORDS_PER_TEST;
    localparam int RESET_CYCLES      = 8;
    localparam int CYCLES_PER_TEST   = 400;
    localparam int IDLE_CHECK_CYCLES = 20;
    localparam int BUSY_START_TEST   = 2;

    logic                              clk;
    logic                              reset;
    logic                              start_i;
    logic [PU_COUNT-1:0]               syndrome_i;
    logic [PU_COUNT*ADDRESS_WIDTH-1:0] roots_o;
    logic [PU_COUNT-1:0]               touching_boundary_o;
    logic                              busy_o;
    logic                              done_o;

    logic [31:0] stim_mem [0:STIM_WORDS-1];
    int          num_tests;
    logic        stim_loaded;

    surface_decoder_top #(
        .CODE_DISTANCE_X(CODE_DISTANCE_X),
        .CODE_DISTANCE_Z(CODE_DISTANCE_Z)
    ) dut (
        .clk                (clk),
        .reset              (reset),
        .start_i            (start_i),
        .syndrome_i         (syndrome_i),
        .roots_o            (roots_o),
        .touching_boundary_o(touching_boundary_o),
        .busy_o             (busy_o),
        .done_o             (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_results(input int base);
        logic [ADDRESS_WIDTH-1:0] expected_root;
        logic [ADDRESS_WIDTH-1:0] got_root;
        logic [PU_COUNT-1:0]      expected_boundary;
        for (int a = 0; a < PU_COUNT; a++) begin
            expected_root = stim_mem[base + 1 + a][ADDRESS_WIDTH-1:0];
            got_root      = roots_o[a*ADDRESS_WIDTH +: ADDRESS_WIDTH];
            assert (got_root == expected_root) else begin
                $display("Error at %0d ns: unit %0d root %0d, expected %0d",
                         $time, a, got_root, expected_root);
                stop_with_failure();
            end
        end
        expected_boundary = stim_mem[base + 1 + PU_COUNT][PU_COUNT-1:0];
        assert (touching_boundary_o == expected_boundary) else begin
            $display("Error at %0d ns: boundary flags %h, expected %h",
                     $time, touching_boundary_o, expected_boundary);
            stop_with_failure();
        end
    endtask

    // no run in progress and no stray done pulse
    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!busy_o && !done_o) else begin
                $display("Error at %0d ns: busy_o=%b done_o=%b while idle",
                         $time, busy_o, done_o);
                stop_with_failure();
            end
        end
    endtask

    task automatic verify_reset_state();
        expect_idle(4);
        for (int a = 0; a < PU_COUNT; a++) begin
            assert (roots_o[a*ADDRESS_WIDTH +: ADDRESS_WIDTH] == ADDRESS_WIDTH'(a)) else begin
                $display("Error at %0d ns: unit %0d does not hold its own address after reset",
                         $time, a);
                stop_with_failure();
            end
        end
        assert (touching_boundary_o == '0) else begin
            $display("Error at %0d ns: boundary flags %h after reset", $time,
                     touching_boundary_o);
            stop_with_failure();
        end
    endtask

    task automatic run_vector(input int t);
        int base;
        base = 1 + t * WORDS_PER_TEST;
        @(posedge clk);
        syndrome_i <= stim_mem[base][PU_COUNT-1:0];
        start_i    <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        assert (busy_o && !done_o) else begin
            $display("Error at %0d ns: busy_o low in the load cycle of test %0d", $time, t);
            stop_with_failure();
        end
        if (t == BUSY_START_TEST) begin
            // second start while the decoder runs
            @(posedge clk);
            start_i <= 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
        end
        @(negedge clk);
        while (!done_o) begin
            assert (busy_o) else begin
                $display("Error at %0d ns: busy_o dropped before done_o in test %0d", $time, t);
                stop_with_failure();
            end
            @(negedge clk);
        end
        assert (!busy_o) else begin
            $display("Error at %0d ns: busy_o still high with done_o in test %0d", $time, t);
            stop_with_failure();
        end
        compare_results(base);
        expect_idle(IDLE_CHECK_CYCLES);
        // results must hold until the next load
        compare_results(base);
    endtask

    initial begin
        reset      <= 1'b1;
        start_i    <= 1'b0;
        syndrome_i <= '0;
        stim_loaded = 1'b0;
        $readmemh("sim/decoder_stim.txt", stim_mem);
        num_tests   = int'(stim_mem[0]);
        stim_loaded = 1'b1;
        assert (num_tests > 0 && num_tests <= MAX_TESTS) else begin
            $display("stimulus file gives an invalid number of tests: %0d", num_tests);
            stop_with_failure();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        verify_reset_state();
        for (int t = 0; t < num_tests; t++) begin
            run_vector(t);
        end
        $display("all tests passed");
        $finish;
    end

    initial begin
        wait (stim_loaded);
        repeat (RESET_CYCLES + num_tests * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired: the decoder did not finish all %0d tests in time",
                 num_tests);
        stop_with_failure();
    end

endmodule

`default_nettype wire

/* sources.f */
logic/decoder_pkg.sv
logic/pu_if.sv
logic/stage_sequencer.sv
logic/processing_unit.sv
logic/neighbor_link.sv
logic/surface_decoder_top.sv
sim/decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the decoder testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module decoder_tb \
    -o decoder_sim

# a failing run exits non-zero, the log is searched in both cases
./obj_dir/decoder_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi

/* sim/decoder_stim.txt */
// columns: syndrome (bit n = unit n), expected root of units 0 to 26, expected boundary flags
// unit address is k*9 + i*3 + j on the 3x3x3 lattice, the first word is the number of tests
8
// no defects
0000000 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 0000000
// pair one z-step apart in plane i=1
0000018 00 01 02 03 03 03 06 07 08 09 0a 0b 03 03 03 0f 10 11 12 13 14 03 03 17 18 19 1a 0000000
// planes i=0 and i=2, two x-steps apart, stay separate
0010400 00 00 00 03 04 05 06 06 06 00 00 00 0c 0d 0e 06 06 06 00 00 00 15 16 17 06 06 06 0000000
// single defect on the i=0 boundary
0000004 00 00 00 03 04 05 06 07 08 09 00 00 0c 0d 0e 0f 10 11 12 13 00 15 16 17 18 19 1a 0000000
// boundary defect with a ud-linked partner
0000804 00 00 00 03 04 05 06 07 08 00 00 00 0c 0d 0e 0f 10 11 12 00 00 15 16 17 18 19 1a 0000000
// x-neighbors, the length-6 link fills in round 3
0002400 00 00 00 00 00 00 06 07 08 00 00 00 00 00 00 0f 10 11 00 00 00 00 00 00 18 19 1a 0000000
// opposite corners of plane i=1 meet in the middle
0800008 00 01 02 03 03 03 06 07 08 09 0a 0b 03 03 03 0f 10 11 12 13 14 03 03 03 18 19 1a 0000000
// every unit a defect
7ffffff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 0000000
